// ==== rtl/blas_pkg.sv ====
// Shared widths, opcodes and bus structs for the BLAS engine
// Referenced by scoped name from RTL and testbench alike

package blas_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes

	localparam int DATA_W = 16;		// One vector element
	localparam int VEC_LEN = 16;		// Elements per vector, words per memory
	localparam int ADDR_W = 4;
	localparam int NUM_ROWS = 2;		// TPU stages in the column
	localparam int STAGE_W = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1;
	localparam int RUN_W = 4;			// Kernel counter, wraps

	// Cycles the MPU waits after a stage and for a read
	localparam int DRAIN_CYCLES = 2;
	localparam int READ_CYCLES = 2;

	////////////////////////////////////////////////////////////////////////////
	// Plain vector types

	typedef logic [DATA_W-1:0] wordT;
	typedef logic [ADDR_W-1:0] addrT;
	typedef logic [2:0] opT;
	typedef logic [STAGE_W-1:0] stageT;
	typedef logic [RUN_W-1:0] runCntT;

	// Host opcodes, anything else is illegal
	localparam opT OP_WRITE = 3'd1;	// Data into input memory
	localparam opT OP_READ = 3'd2;		// Word from output memory
	localparam opT OP_ADD = 3'd3;
	localparam opT OP_MUL = 3'd4;		// Low half of the product

	////////////////////////////////////////////////////////////////////////////
	// Structs

	typedef struct packed {
		opT op;
		addrT addr;
		wordT data;		// Write value or kernel scalar
	} mpuIfT;

	typedef struct packed {
		logic valid;
		stageT stage;	// Target TPU row
		opT op;
		addrT idx;
		wordT scalar;
	} instrT;

	typedef struct packed {
		logic en;
		addrT addr;
		wordT data;
	} memWrT;

	typedef struct packed {
		logic busy;
		logic badOp;	// Sticky until reset
		runCntT runCount;
	} mpuStatT;

	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		READ_WAIT,
		ISSUE,
		DRAIN,
		ACK,
		RELEASE
	} mpuStateT;

endpackage

// ==== rtl/DataMem.sv ====
// Vector memory placed between TPU rows
// One write port, one read port with the data registered

module DataMem (
	input	logic				clock,
	input	logic				rstN,
	input	blas_pkg::memWrT	wr,
	input	blas_pkg::addrT		rdAddr,
	output	blas_pkg::wordT		rdData
);

	blas_pkg::wordT mem [blas_pkg::VEC_LEN];

	// Write lands on the edge
	always_ff @(posedge clock) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// Read data one cycle after the address
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			rdData <= '0;
		end else begin
			rdData <= mem[rdAddr];	// Old word on a same-cycle write
		end
	end

endmodule

// ==== rtl/Tpu.sv ====
// One stage of the processing column
// Streams a vector from the memory above, applies the scalar op
// and stores each result into the memory below

module Tpu #(
	parameter int ROW = 0
) (
	input	logic				clock,
	input	logic				rstN,
	input	blas_pkg::instrT	instr,
	output	blas_pkg::addrT		rdAddr,
	input	blas_pkg::wordT		rdData,
	output	blas_pkg::memWrT	wr
);

	logic hit;

	// Stage 1 pipeline, waits for the memory read
	logic pipeValid;
	blas_pkg::addrT pipeIdx;
	blas_pkg::opT pipeOp;
	blas_pkg::wordT pipeScalar;

	// Stage 2, the registered write
	blas_pkg::wordT product;
	blas_pkg::wordT result;
	logic wrEn;
	blas_pkg::addrT wrAddr;
	blas_pkg::wordT wrData;

	////////////////////////////////////////////////////////////////////////////
	// Accept

	assign hit = instr.valid && (instr.stage == blas_pkg::stageT'(ROW));
	assign rdAddr = instr.idx;		// Memory registers it on the accept edge

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			pipeValid <= 1'b0;
		end else begin
			pipeValid <= hit;
		end
	end

	always_ff @(posedge clock) begin
		pipeIdx <= instr.idx;
		pipeOp <= instr.op;
		pipeScalar <= instr.scalar;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compute and store

	always_comb begin
		product = rdData * pipeScalar;	// Low half only
		if (pipeOp == blas_pkg::OP_MUL) begin
			result = product;	// Wrapping multiply
		end else begin
			result = rdData + pipeScalar;
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wrEn <= 1'b0;
		end else begin
			wrEn <= pipeValid;
		end
	end

	always_ff @(posedge clock) begin
		wrAddr <= pipeIdx;
		wrData <= result;
	end

	assign wr = '{en: wrEn, addr: wrAddr, data: wrData};

endmodule

// ==== rtl/Mpu.sv ====
// Management processor for the engine
// Serves host commands over a four-phase req/ack port: memory writes,
// output reads and kernels issued stage by stage to the TPU column

module Mpu (
	input	logic				clock,
	input	logic				rstN,
	input	logic				hostReq,
	output	logic				hostAck,
	input	blas_pkg::mpuIfT	hostCmd,
	output	blas_pkg::wordT		readData,
	output	blas_pkg::instrT	instr,
	output	blas_pkg::memWrT	inWr,
	output	blas_pkg::addrT		outRdAddr,
	input	blas_pkg::wordT		outRdData,
	output	blas_pkg::mpuStatT	status
);

	blas_pkg::mpuStateT state;
	blas_pkg::mpuIfT cmdReg;		// Command held for the whole transaction
	blas_pkg::stageT stageCnt;
	blas_pkg::addrT idxCnt;
	logic [1:0] drainCnt;			// Drain cycles, also the read wait
	logic badOp;
	blas_pkg::runCntT runCount;
	logic busy;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= blas_pkg::IDLE;
			stageCnt <= '0;
			idxCnt <= '0;
			drainCnt <= '0;
			badOp <= 1'b0;
			runCount <= '0;
		end else begin
			unique case (state)
				blas_pkg::IDLE: begin
					if (hostReq) begin
						stageCnt <= '0;
						idxCnt <= '0;
						drainCnt <= '0;
						case (hostCmd.op)
							blas_pkg::OP_WRITE: state <= blas_pkg::WRITE;
							blas_pkg::OP_READ: state <= blas_pkg::READ_WAIT;
							blas_pkg::OP_ADD,
							blas_pkg::OP_MUL: state <= blas_pkg::ISSUE;
							default: begin
								badOp <= 1'b1;	// Acked like a write, no memory access
								state <= blas_pkg::WRITE;
							end
						endcase
					end
				end

				blas_pkg::WRITE: state <= blas_pkg::ACK;

				blas_pkg::READ_WAIT: begin
					if (drainCnt == 2'(blas_pkg::READ_CYCLES - 1)) begin
						state <= blas_pkg::ACK;
					end else begin
						drainCnt <= drainCnt + 2'd1;
					end
				end

				// One element per cycle into the current stage
				blas_pkg::ISSUE: begin
					if (idxCnt == blas_pkg::addrT'(blas_pkg::VEC_LEN - 1)) begin
						idxCnt <= '0;
						drainCnt <= '0;
						state <= blas_pkg::DRAIN;
					end else begin
						idxCnt <= idxCnt + 1'b1;
					end
				end

				// Let the last writes of the stage land
				blas_pkg::DRAIN: begin
					if (drainCnt == 2'(blas_pkg::DRAIN_CYCLES - 1)) begin
						if (stageCnt == blas_pkg::stageT'(blas_pkg::NUM_ROWS - 1)) begin
							runCount <= runCount + 1'b1;	// Wraps
							state <= blas_pkg::ACK;
						end else begin
							stageCnt <= stageCnt + 1'b1;
							state <= blas_pkg::ISSUE;
						end
					end else begin
						drainCnt <= drainCnt + 2'd1;
					end
				end

				blas_pkg::ACK: begin
					if (!hostReq) begin
						state <= blas_pkg::RELEASE;
					end
				end

				blas_pkg::RELEASE: state <= blas_pkg::IDLE;	// Ack low, turnaround

				default: state <= blas_pkg::IDLE;
			endcase
		end
	end

	// Command and read result
	always_ff @(posedge clock) begin
		if (state == blas_pkg::IDLE && hostReq) begin
			cmdReg <= hostCmd;
		end
		if (state == blas_pkg::READ_WAIT && drainCnt == 2'(blas_pkg::READ_CYCLES - 1)) begin
			readData <= outRdData;	// Held through the ack phase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs

	assign hostAck = (state == blas_pkg::ACK);
	assign busy = (state == blas_pkg::WRITE) || (state == blas_pkg::READ_WAIT) ||
		(state == blas_pkg::ISSUE) || (state == blas_pkg::DRAIN);

	assign inWr = '{
		en: (state == blas_pkg::WRITE) && (cmdReg.op == blas_pkg::OP_WRITE),
		addr: cmdReg.addr,
		data: cmdReg.data
	};

	assign outRdAddr = cmdReg.addr;

	// Broadcast to every TPU, only the matching row acts
	assign instr = '{
		valid: (state == blas_pkg::ISSUE),
		stage: stageCnt,
		op: cmdReg.op,
		idx: idxCnt,
		scalar: cmdReg.data
	};

	assign status = '{busy: busy, badOp: badOp, runCount: runCount};

endmodule

// ==== rtl/BlasEngine.sv ====
// Top of the BLAS engine: the MPU, one TPU column and the memories
// between the rows; memory 0 is host input, memory NUM_ROWS is output

module BlasEngine (
	input	logic				clock,
	input	logic				rstN,
	input	logic				hostReq,
	output	logic				hostAck,
	input	blas_pkg::mpuIfT	hostCmd,
	output	blas_pkg::wordT		readData,
	output	blas_pkg::mpuStatT	status
);

	blas_pkg::instrT instr;

	// Indexed by memory, row r reads r and writes r+1
	blas_pkg::memWrT memWr [blas_pkg::NUM_ROWS+1];
	blas_pkg::addrT memRdAddr [blas_pkg::NUM_ROWS+1];
	blas_pkg::wordT memRdData [blas_pkg::NUM_ROWS+1];

	Mpu mpu (
		.clock(		clock							),
		.rstN(		rstN							),
		.hostReq(	hostReq							),
		.hostAck(	hostAck							),
		.hostCmd(	hostCmd							),
		.readData(	readData						),
		.instr(		instr							),
		.inWr(		memWr[0]						),	// Host writes
		.outRdAddr(	memRdAddr[blas_pkg::NUM_ROWS]	),
		.outRdData(	memRdData[blas_pkg::NUM_ROWS]	),
		.status(	status							)
	);

	////////////////////////////////////////////////////////////////////////////
	// TPU column

	for (genvar row = 0; row < blas_pkg::NUM_ROWS; ++row) begin : genTpu
		Tpu #(
			.ROW(row)
		) tpu (
			.clock(		clock				),
			.rstN(		rstN				),
			.instr(		instr				),
			.rdAddr(	memRdAddr[row]		),
			.rdData(	memRdData[row]		),
			.wr(		memWr[row+1]		)
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Memories, one above each row plus the output one

	for (genvar m = 0; m <= blas_pkg::NUM_ROWS; ++m) begin : genMem
		DataMem dataMem (
			.clock(		clock				),
			.rstN(		rstN				),
			.wr(		memWr[m]			),
			.rdAddr(	memRdAddr[m]		),
			.rdData(	memRdData[m]		)
		);
	end

endmodule

// ==== verification/blasEngine_properties.sv ====
// Concurrent checks on the host handshake and the status outputs
// Bound into BlasEngine from the testbench

module blasEngine_properties (
	input	logic				clock,
	input	logic				rstN,
	input	logic				hostReq,
	input	logic				hostAck,
	input	blas_pkg::mpuStatT	status
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////////////////////////////////////////
	// Four-phase handshake

	ackNeedsReq: assert property (@(posedge clock) disable iff (!rstN)
		$rose(hostAck) |-> hostReq)
		else $error("hostAck rose while hostReq was low");

	// Ack may only drop once the request is gone
	ackHoldsWhileReq: assert property (@(posedge clock) disable iff (!rstN)
		hostAck && hostReq |=> hostAck)
		else $error("hostAck fell while hostReq was still high");

	////////////////////////////////////////////////////////////////////////////
	// Status

	busyOnAccept: assert property (@(posedge clock) disable iff (!rstN)
		$rose(hostReq) |-> ##[1:2] status.busy)
		else $error("busy did not rise after a request");

	busyUntilAck: assert property (@(posedge clock) disable iff (!rstN)
		status.busy |=> status.busy || hostAck)
		else $error("busy dropped before hostAck rose");

endmodule

// ==== verification/tbBlasEngine.sv ====
// Table-driven testbench for BlasEngine
// Writes random vectors, runs add and multiply kernels and reads results back
// through the host handshake, checked against a reference model

module tbBlasEngine;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_STEP = blas_pkg::NUM_ROWS * (blas_pkg::VEC_LEN + 2) + 10;

	// One table entry, command plus what should come back
	typedef struct packed {
		blas_pkg::mpuIfT cmd;
		logic checkRead;
		blas_pkg::wordT expRead;
		blas_pkg::mpuStatT expStat;
	} stepT;

	logic clock;
	logic rstN;
	logic hostReq;
	logic hostAck;
	blas_pkg::mpuIfT hostCmd;
	blas_pkg::wordT readData;
	blas_pkg::mpuStatT status;

	stepT steps[$];
	blas_pkg::wordT refIn [blas_pkg::VEC_LEN];
	blas_pkg::wordT refOut [blas_pkg::VEC_LEN];
	logic refBadOp;
	blas_pkg::runCntT refRun;
	integer seed = 32'h8019_711c;
	int failCount = 0;
	int cycleCount = 0;
	int timeoutLimit = 0;

	BlasEngine dut (
		.clock(		clock		),
		.rstN(		rstN		),
		.hostReq(	hostReq		),
		.hostAck(	hostAck		),
		.hostCmd(	hostCmd		),
		.readData(	readData	),
		.status(	status		)
	);

	bind BlasEngine blasEngine_properties props (
		.clock(		clock		),
		.rstN(		rstN		),
		.hostReq(	hostReq		),
		.hostAck(	hostAck		),
		.status(	status		)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;	// 40 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic blas_pkg::wordT applyOp(input blas_pkg::opT op,
		input blas_pkg::wordT x, input blas_pkg::wordT s);
		if (op == blas_pkg::OP_MUL) begin
			return blas_pkg::wordT'(x * s);	// Low 16 bits only
		end
		return x + s;
	endfunction

	// Every stage applies the same op and scalar
	function automatic blas_pkg::wordT kernelOutput(input blas_pkg::opT op,
		input blas_pkg::wordT s, input blas_pkg::wordT x);
		blas_pkg::wordT v;
		v = x;
		for (int r = 0; r < blas_pkg::NUM_ROWS; r++) begin
			v = applyOp(op, v, s);
		end
		return v;
	endfunction

	task automatic addStep(input blas_pkg::opT op, input blas_pkg::addrT addr,
		input blas_pkg::wordT data);
		stepT s;
		s.cmd = '{op: op, addr: addr, data: data};
		s.checkRead = (op == blas_pkg::OP_READ);
		s.expRead = s.checkRead ? refOut[addr] : '0;
		case (op)
			blas_pkg::OP_WRITE: refIn[addr] = data;
			blas_pkg::OP_READ: ;
			blas_pkg::OP_ADD,
			blas_pkg::OP_MUL: begin
				for (int i = 0; i < blas_pkg::VEC_LEN; i++) begin
					refOut[i] = kernelOutput(op, data, refIn[i]);
				end
				refRun = refRun + 1'b1;
			end
			default: refBadOp = 1'b1;
		endcase
		s.expStat = '{busy: 1'b0, badOp: refBadOp, runCount: refRun};
		steps.push_back(s);
	endtask

	task automatic readAll();
		for (int i = 0; i < blas_pkg::VEC_LEN; i++) begin
			addStep(blas_pkg::OP_READ, blas_pkg::addrT'(i), '0);
		end
	endtask

	task automatic buildTable();
		refBadOp = 1'b0;
		refRun = '0;
		for (int i = 0; i < blas_pkg::VEC_LEN; i++) begin
			addStep(blas_pkg::OP_WRITE, blas_pkg::addrT'(i), blas_pkg::wordT'($random(seed)));
		end
		addStep(blas_pkg::OP_ADD, '0, blas_pkg::wordT'($random(seed)));
		readAll();
		addStep(blas_pkg::OP_MUL, '0, blas_pkg::wordT'($random(seed)));	// Same input again
		readAll();
		addStep(3'd0, 4'd3, blas_pkg::wordT'($random(seed)));	// Illegal ops
		addStep(3'd7, 4'd5, blas_pkg::wordT'($random(seed)));
		readAll();
		// 17 kernels in all, runCount passes 15 and wraps
		for (int k = 0; k < 15; k++) begin
			addStep((k % 2) ? blas_pkg::OP_MUL : blas_pkg::OP_ADD, '0,
				blas_pkg::wordT'($random(seed)));
		end
		readAll();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic checkWord(input string name, input blas_pkg::wordT got,
		input blas_pkg::wordT exp);
		if (got !== exp) begin
			failCount++;
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Word mismatch");
		end
	endtask

	task automatic checkStatus(input string name, input blas_pkg::mpuStatT got,
		input blas_pkg::mpuStatT exp);
		if (got !== exp) begin
			failCount++;
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Status mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failCount++;
			$display("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Flag mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host driver

	task automatic hostTransaction(input blas_pkg::mpuIfT cmd,
		output blas_pkg::wordT rdWord, output blas_pkg::mpuStatT stat);
		@(posedge clock);
		hostCmd <= cmd;			// Command settles before the request
		@(posedge clock);
		hostReq <= 1'b1;
		@(negedge clock);
		while (!hostAck) begin
			@(negedge clock);
		end
		rdWord = readData;		// Valid while ack is high
		@(posedge clock);
		hostReq <= 1'b0;
		@(negedge clock);
		while (hostAck) begin
			@(negedge clock);
		end
		stat = status;
	endtask

	initial begin
		wait (timeoutLimit > 0);
		while (cycleCount < timeoutLimit) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
		$display("TESTBENCH FAILED");
		$fatal(1, "Timeout");
	end

	initial begin
		blas_pkg::wordT rdWord;
		blas_pkg::mpuStatT stat;
		rstN = 1'b0;
		hostReq = 1'b0;
		hostCmd = '0;
		buildTable();
		timeoutLimit = RESET_CYCLES + steps.size() * CYCLES_PER_STEP;

		repeat (RESET_CYCLES) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		checkFlag("hostAck", hostAck, 1'b0);
		checkStatus("status", status, '0);

		foreach (steps[i]) begin
			hostTransaction(steps[i].cmd, rdWord, stat);
			if (steps[i].checkRead) begin
				checkWord($sformatf("readData step %0d", i), rdWord, steps[i].expRead);
			end
			checkStatus($sformatf("status step %0d", i), stat, steps[i].expStat);
		end

		if (failCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
rtl/blas_pkg.sv
rtl/DataMem.sv
rtl/Tpu.sv
rtl/Mpu.sv
rtl/BlasEngine.sv
verification/blasEngine_properties.sv
verification/tbBlasEngine.sv
